//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and address width
`define WORD_W 16

// Architectural register count
`define REG_COUNT 16

// Bytes between consecutive instructions
`define PC_STEP 2

`endif

//--- rtl/isaPkg.sv
`include "cpu_defs.svh"

package isaPkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

    // Opcodes not listed here decode as no-ops
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opSub = 4'h1,
        opXor = 4'h2,
        opSll = 4'h3,
        opLw  = 4'h8,
        opSw  = 4'h9,
        opLlb = 4'hA,
        opB   = 4'hC,
        opHlt = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {
        condNe     = 3'b000,
        condEq     = 3'b001,
        condGt     = 3'b010,
        condLt     = 3'b011,
        condGe     = 3'b100,
        condLe     = 3'b101,
        condOv     = 3'b110,
        condAlways = 3'b111
    } condT;

    // B and LLB reuse the low fields for their immediates
    typedef struct packed {
        opcodeT  opcode;
        regAddrT rd;
        regAddrT rs;
        regAddrT rt;
    } instrT;

endpackage

//--- rtl/pipePkg.sv
`include "cpu_defs.svh"

package pipePkg;
    import isaPkg::*;

    typedef logic [`WORD_W-1:0] wordT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluXor, aluSll} aluOpT;

    // Operand source in EX
    typedef enum logic [1:0] {srcReg, srcMem, srcWb} fwdSelT;

    // All-zero word is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  halt;
        logic  aluSrc;    // 1 selects the immediate
        aluOpT aluOp;
        logic  zEn;
        logic  vEn;
        logic  nEn;
        logic  wbSel;     // 1 selects load data
    } ctrlT;

    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flagT;

    typedef struct packed {
        instrT instr;
        wordT  incPc;
    } fdT;

    typedef struct packed {
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        wordT    rsData;
        wordT    rtData;
        wordT    imm;
    } dxT;

    typedef struct packed {
        ctrlT    ctrl;
        regAddrT rt;
        regAddrT rd;
        wordT    alu;
        wordT    storeData;
    } xmT;

    typedef struct packed {
        logic    regWrite;
        logic    halt;
        logic    wbSel;
        regAddrT rd;
        wordT    alu;
        wordT    loadData;
    } mwT;

endpackage

//--- rtl/stageRegister.sv
`timescale 1ns/1ps

module stageRegister #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    enable,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Zero payload is a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regFile
    import pipePkg::*;
(
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [$clog2(`REG_COUNT)-1:0] rsAddr,
    input  logic [$clog2(`REG_COUNT)-1:0] rtAddr,
    input  logic [$clog2(`REG_COUNT)-1:0] wrAddr,
    input  logic                         wrEn,
    input  wordT                         wrData,
    output wordT                         rsData,
    output wordT                         rtData
);

    wordT regs [`REG_COUNT];
    logic writeLive;

    // Register 0 is never written and stays zero
    assign writeLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-back value bypasses to a same-cycle read
    assign rsData = (writeLive && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (writeLive && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

//--- rtl/decodeControl.sv
`timescale 1ns/1ps

module decodeControl
    import isaPkg::*;
    import pipePkg::*;
(
    input  instrT   instr,
    input  wordT    incPc,
    input  flagT    flags,
    output ctrlT    ctrl,
    output regAddrT rsAddr,
    output regAddrT rtAddr,
    output regAddrT rdAddr,
    output wordT    imm,
    output logic    branchTaken,
    output wordT    branchTarget
);

    logic [8:0] brOffset;
    logic       isBranch;
    logic       condMet;

    assign rdAddr = instr.rd;

    // Word offset shifted left by one
    assign brOffset     = {instr.rd[0], instr.rs, instr.rt};
    assign branchTarget = incPc + {{($bits(wordT)-10){brOffset[8]}}, brOffset, 1'b0};

    always_comb begin
        case (condT'(instr.rd[3:1]))
            condNe:  condMet = !flags.z;
            condEq:  condMet = flags.z;
            condGt:  condMet = !flags.z && !flags.n;
            condLt:  condMet = flags.n;
            condGe:  condMet = !flags.n;
            condLe:  condMet = flags.z || flags.n;
            condOv:  condMet = flags.v;
            default: condMet = 1'b1;
        endcase
    end

    assign branchTaken = isBranch && condMet;

    always_comb begin
        ctrl     = '0;
        rsAddr   = '0;
        rtAddr   = '0;
        imm      = '0;
        isBranch = 1'b0;
        case (instr.opcode)
            opAdd, opSub: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (instr.opcode == opSub) ? aluSub : aluAdd;
                ctrl.zEn      = 1'b1;
                ctrl.vEn      = 1'b1;
                ctrl.nEn      = 1'b1;
                rsAddr        = instr.rs;
                rtAddr        = instr.rt;
            end
            opXor: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluXor;
                ctrl.zEn      = 1'b1;
                rsAddr        = instr.rs;
                rtAddr        = instr.rt;
            end
            opSll: begin
                // Shift amount sits in the rt field
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluSll;
                ctrl.aluSrc   = 1'b1;
                ctrl.zEn      = 1'b1;
                rsAddr        = instr.rs;
                imm           = {{($bits(wordT)-4){1'b0}}, instr.rt};
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.wbSel    = 1'b1;
                rsAddr        = instr.rs;
                imm           = {{($bits(wordT)-5){instr.rt[3]}}, instr.rt, 1'b0};
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                rsAddr        = instr.rs;
                rtAddr        = instr.rd;
                imm           = {{($bits(wordT)-5){instr.rt[3]}}, instr.rt, 1'b0};
            end
            opLlb: begin
                // r0 plus the zero-extended byte
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                imm           = {{($bits(wordT)-8){1'b0}}, instr.rs, instr.rt};
            end
            opB:     isBranch  = 1'b1;
            opHlt:   ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  regAddrT dRs,
    input  regAddrT dRt,
    input  logic    dIsStore,
    input  logic    dIsCondBranch,
    input  ctrlT    xCtrl,
    input  regAddrT xRs,
    input  regAddrT xRt,
    input  regAddrT xRd,
    input  regAddrT mRd,
    input  regAddrT wRd,
    input  logic    mRegWrite,
    input  logic    wRegWrite,
    input  logic    mIsStore,
    input  regAddrT mRt,
    output logic    stall,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB,
    output logic    fwdMem
);

    logic loadUse;
    logic flagWait;

    // Youngest producer wins
    function automatic fwdSelT pickSource(regAddrT src);
        if (src == '0) return srcReg;
        if (mRegWrite && mRd == src) return srcMem;
        if (wRegWrite && wRd == src) return srcWb;
        return srcReg;
    endfunction

    // A store's data register is picked up later in MEM
    assign loadUse = xCtrl.memRead && (xRd != '0) &&
                     (xRd == dRs || (xRd == dRt && !dIsStore));

    // Flags are not written until EX finishes
    assign flagWait = dIsCondBranch && (xCtrl.zEn || xCtrl.vEn || xCtrl.nEn);

    assign stall = loadUse || flagWait;
    assign fwdA  = pickSource(xRs);
    assign fwdB  = pickSource(xRt);

    assign fwdMem = mIsStore && wRegWrite && (wRd != '0) && (wRd == mRt);

endmodule

//--- rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
    import pipePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  dxT     dx,
    input  fwdSelT fwdA,
    input  fwdSelT fwdB,
    input  wordT   mAlu,
    input  wordT   wbData,
    output wordT   result,
    output wordT   storeData,
    output flagT   flags
);

    localparam int topBit = $bits(wordT) - 1;

    wordT opA;
    wordT opB;
    wordT rtValue;
    logic overflow;

    function automatic wordT pickOperand(fwdSelT sel, wordT regValue);
        case (sel)
            srcMem:  return mAlu;
            srcWb:   return wbData;
            default: return regValue;
        endcase
    endfunction

    assign opA       = pickOperand(fwdA, dx.rsData);
    assign rtValue   = pickOperand(fwdB, dx.rtData);
    assign opB       = dx.ctrl.aluSrc ? dx.imm : rtValue;
    assign storeData = rtValue;

    always_comb begin
        overflow = 1'b0;
        case (dx.ctrl.aluOp)
            aluAdd: begin
                result   = opA + opB;
                overflow = (opA[topBit] == opB[topBit]) && (result[topBit] != opA[topBit]);
            end
            aluSub: begin
                result   = opA - opB;
                overflow = (opA[topBit] != opB[topBit]) && (result[topBit] != opA[topBit]);
            end
            aluXor:  result = opA ^ opB;
            default: result = opA << opB[3:0];
        endcase
    end

    // Each flag updates only under its own enable
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else begin
            if (dx.ctrl.zEn) flags.z <= (result == '0);
            if (dx.ctrl.vEn) flags.v <= overflow;
            if (dx.ctrl.nEn) flags.n <= result[topBit];
        end
    end

endmodule

//--- rtl/cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic clk,
    input  logic rstN,
    output wordT pc,
    input  wordT instr,
    output wordT dAddr,
    output wordT dWrData,
    output logic dWrite,
    input  wordT dRdData,
    output logic hlt
);

    fdT      fdd, fdq;
    dxT      dxd, dxq;
    xmT      xmd, xmq;
    mwT      mwd, mwq;
    ctrlT    dCtrl;
    regAddrT dRs, dRt, dRd;
    wordT    dImm, rsData, rtData, branchTarget;
    wordT    exResult, exStoreData, wbData;
    flagT    curFlags;
    fwdSelT  fwdA, fwdB;
    logic    fwdMem, stall, branchTaken, takeBranch;
    logic    fetchHlt, fdValid, haltSeen;

    // Fetch
    assign fetchHlt   = (fdd.instr.opcode == opHlt) && !takeBranch;
    assign takeBranch = fdValid && branchTaken && !stall;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (takeBranch) begin
            pc <= branchTarget;
        end else if (!stall && !fetchHlt) begin
            pc <= pc + wordT'(`PC_STEP);
        end
    end

    // Marks a real instruction in IF/ID, since an all-zero word is ADD
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fdValid <= 1'b0;
        end else if (takeBranch) begin
            fdValid <= 1'b0;
        end else if (!stall) begin
            fdValid <= 1'b1;
        end
    end

    always_comb begin
        fdd.instr = instrT'(instr);
        fdd.incPc = pc + wordT'(`PC_STEP);
    end

    stageRegister #(.payloadT(fdT)) ifId (
        .clk(clk), .rstN(rstN), .enable(!stall), .flush(takeBranch), .d(fdd), .q(fdq)
    );

    // Decode
    decodeControl decode (
        .instr(fdq.instr), .incPc(fdq.incPc), .flags(curFlags), .ctrl(dCtrl),
        .rsAddr(dRs), .rtAddr(dRt), .rdAddr(dRd), .imm(dImm),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .rsAddr(dRs), .rtAddr(dRt),
        .wrAddr(mwq.rd), .wrEn(mwq.regWrite), .wrData(wbData),
        .rsData(rsData), .rtData(rtData)
    );

    // Load data is not ready in MEM, so a load never forwards from there
    hazardUnit hazards (
        .dRs(dRs), .dRt(dRt), .dIsStore(dxd.ctrl.memWrite),
        .dIsCondBranch(fdValid && fdq.instr.opcode == opB &&
                       condT'(fdq.instr.rd[3:1]) != condAlways),
        .xCtrl(dxq.ctrl), .xRs(dxq.rs), .xRt(dxq.rt), .xRd(dxq.rd),
        .mRd(xmq.rd), .wRd(mwq.rd),
        .mRegWrite(xmq.ctrl.regWrite && !xmq.ctrl.memRead), .wRegWrite(mwq.regWrite),
        .mIsStore(xmq.ctrl.memWrite), .mRt(xmq.rt),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB), .fwdMem(fwdMem)
    );

    always_comb begin
        dxd.ctrl   = fdValid ? dCtrl : '0;
        dxd.rs     = dRs;
        dxd.rt     = dRt;
        dxd.rd     = dRd;
        dxd.rsData = rsData;
        dxd.rtData = rtData;
        dxd.imm    = dImm;
    end

    stageRegister #(.payloadT(dxT)) idEx (
        .clk(clk), .rstN(rstN), .enable(1'b1), .flush(stall), .d(dxd), .q(dxq)
    );

    // Execute
    executeUnit execute (
        .clk(clk), .rstN(rstN), .dx(dxq), .fwdA(fwdA), .fwdB(fwdB),
        .mAlu(xmq.alu), .wbData(wbData),
        .result(exResult), .storeData(exStoreData), .flags(curFlags)
    );

    always_comb begin
        xmd.ctrl      = dxq.ctrl;
        xmd.rt        = dxq.rt;
        xmd.rd        = dxq.rd;
        xmd.alu       = exResult;
        xmd.storeData = exStoreData;
    end

    stageRegister #(.payloadT(xmT)) exMem (
        .clk(clk), .rstN(rstN), .enable(1'b1), .flush(1'b0), .d(xmd), .q(xmq)
    );

    // Memory
    assign dAddr   = xmq.alu;
    assign dWrData = fwdMem ? wbData : xmq.storeData;
    assign dWrite  = xmq.ctrl.memWrite;

    always_comb begin
        mwd.regWrite = xmq.ctrl.regWrite;
        mwd.halt     = xmq.ctrl.halt;
        mwd.wbSel    = xmq.ctrl.wbSel;
        mwd.rd       = xmq.rd;
        mwd.alu      = xmq.alu;
        mwd.loadData = dRdData;
    end

    stageRegister #(.payloadT(mwT)) memWb (
        .clk(clk), .rstN(rstN), .enable(1'b1), .flush(1'b0), .d(mwd), .q(mwq)
    );

    // Write-back
    assign wbData = mwq.wbSel ? mwq.loadData : mwq.alu;

    // Halt stays up once HLT retires
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haltSeen <= 1'b0;
        end else if (mwq.halt) begin
            haltSeen <= 1'b1;
        end
    end

    assign hlt = haltSeen || mwq.halt;

endmodule

//--- verification/tbCpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tbCpu
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int memWords     = 256;
    localparam int programCount = 6;
    localparam int resetCycles  = 5;
    localparam int hltTimeout   = 2000;
    localparam int quietCycles  = 12;
    localparam int preloadCount = `REG_COUNT - 1;

    typedef struct packed {
        wordT addr;
        wordT data;
    } storeT;

    logic  clk;
    logic  rstN;
    wordT  pc;
    wordT  instr;
    wordT  dAddr;
    wordT  dWrData;
    logic  dWrite;
    wordT  dRdData;
    logic  hlt;

    wordT  imem [memWords];
    wordT  dmem [memWords];
    wordT  fillMem [memWords];
    wordT  expMem [memWords];
    logic  loadMem;
    storeT seenStores [$];
    storeT expStores [$];
    int    storeErrors;
    int    memErrors;
    int    ctrlErrors;
    logic  timedOut;

    cpu u_dut (
        .clk(clk), .rstN(rstN), .pc(pc), .instr(instr),
        .dAddr(dAddr), .dWrData(dWrData), .dWrite(dWrite),
        .dRdData(dRdData), .hlt(hlt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Combinational instruction and load ports indexed by word
    assign instr   = imem[pc[8:1]];
    assign dRdData = dmem[dAddr[8:1]];

    always @(posedge clk) begin
        if (loadMem) begin
            dmem <= fillMem;
        end else if (dWrite) begin
            dmem[dAddr[8:1]] <= dWrData;
        end
    end

    // Store monitor samples mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            seenStores.delete();
        end else if (dWrite) begin
            seenStores.push_back({dAddr, dWrData});
        end
    end

    function automatic int randBelow(int n);
        return int'($urandom % n);
    endfunction

    // Small register window so neighbours depend on each other
    function automatic int pickReg();
        return randBelow(8);
    endfunction

    function automatic wordT encode(logic [3:0] op, int a, int b, int c);
        return {op, 4'(a), 4'(b), 4'(c)};
    endfunction

    task automatic buildProgram();
        int bodyLen;
        int hltIdx;
        int idx;
        int kind;
        int r;
        int maxOff;
        bodyLen = 40 + randBelow(41);
        hltIdx  = preloadCount + bodyLen;
        for (int a = 0; a < memWords; a++) begin
            imem[a]    = {4'hF, 12'(a)};
            fillMem[a] = wordT'($urandom);
        end
        for (int k = 1; k <= preloadCount; k++) begin
            imem[k - 1] = encode(opLlb, k, randBelow(16), randBelow(16));
        end
        idx = preloadCount;
        while (idx < hltIdx) begin
            kind = randBelow(10);
            if (kind == 4) begin
                imem[idx] = encode(opLw, pickReg(), pickReg(), randBelow(16));
            end else if (kind == 5) begin
                imem[idx] = encode(opSw, pickReg(), pickReg(), randBelow(16));
            end else if (kind == 6 || kind == 7) begin
                // Forward targets never pass HLT
                maxOff = hltIdx - (idx + 1);
                if (maxOff > 5) maxOff = 5;
                imem[idx] = encode(opB, 2 * randBelow(8), 0, randBelow(maxOff + 1));
            end else if (kind >= 8 && idx + 1 < hltIdx) begin
                // Load followed by an immediate use or a store of the loaded register
                r = 1 + randBelow(7);
                imem[idx] = encode(opLw, r, pickReg(), randBelow(16));
                idx++;
                if (kind == 8) begin
                    imem[idx] = encode(4'(randBelow(3)), pickReg(), pickReg(), r);
                end else begin
                    imem[idx] = encode(opSw, r, pickReg(), randBelow(16));
                end
            end else begin
                imem[idx] = encode(4'(randBelow(4)), pickReg(), pickReg(), pickReg());
            end
            idx++;
        end
        imem[hltIdx] = encode(opHlt, 0, 0, 0);
    endtask

    // Sequential model of the instruction set
    function automatic void runReference();
        wordT       regs [`REG_COUNT];
        flagT       f;
        instrT      ins;
        wordT       a;
        wordT       b;
        wordT       res;
        wordT       addr;
        logic [8:0] off9;
        logic       taken;
        int         ip;
        int         steps;
        int         s;
        expStores.delete();
        expMem = fillMem;
        regs   = '{default: '0};
        f      = '0;
        ip     = 0;
        steps  = 0;
        ins    = instrT'(imem[ip]);
        while (ins.opcode != opHlt && steps < 4096) begin
            a    = regs[ins.rs];
            b    = regs[ins.rt];
            addr = a + wordT'(2 * int'($signed(ins.rt)));
            ip   = ip + 1;
            case (ins.opcode)
                opAdd, opSub: begin
                    if (ins.opcode == opAdd) begin
                        res = a + b;
                        s   = int'($signed(a)) + int'($signed(b));
                    end else begin
                        res = a - b;
                        s   = int'($signed(a)) - int'($signed(b));
                    end
                    f.z = (res == '0);
                    f.n = res[`WORD_W-1];
                    f.v = (s > 32767) || (s < -32768);
                    if (ins.rd != '0) regs[ins.rd] = res;
                end
                opXor, opSll: begin
                    res = (ins.opcode == opXor) ? (a ^ b) : (a << ins.rt);
                    f.z = (res == '0);
                    if (ins.rd != '0) regs[ins.rd] = res;
                end
                opLw: begin
                    if (ins.rd != '0) regs[ins.rd] = expMem[addr[8:1]];
                end
                opSw: begin
                    expMem[addr[8:1]] = regs[ins.rd];
                    expStores.push_back({addr, regs[ins.rd]});
                end
                opLlb: begin
                    if (ins.rd != '0) regs[ins.rd] = {8'h00, ins.rs, ins.rt};
                end
                opB: begin
                    off9 = {ins.rd[0], ins.rs, ins.rt};
                    case (condT'(ins.rd[3:1]))
                        condNe:  taken = !f.z;
                        condEq:  taken = f.z;
                        condGt:  taken = !f.z && !f.n;
                        condLt:  taken = f.n;
                        condGe:  taken = !f.n;
                        condLe:  taken = f.z || f.n;
                        condOv:  taken = f.v;
                        default: taken = 1'b1;
                    endcase
                    if (taken) ip = ip + int'($signed(off9));
                end
                default: ;
            endcase
            steps++;
            ins = instrT'(imem[ip]);
        end
    endfunction

    task automatic checkStore(int idx, storeT got, storeT exp);
        if (got !== exp) begin
            storeErrors++;
            $display("FAILED store %0d dAddr/dWrData: got %h/%h expected %h/%h",
                     idx, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic checkMemWord(int idx, wordT got, wordT exp);
        if (got !== exp) begin
            memErrors++;
            $display("FAILED dmem[%0d]: got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic checkLevel(string name, logic got, logic exp);
        if (got !== exp) begin
            ctrlErrors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkPc(wordT got, wordT exp);
        if (got !== exp) begin
            ctrlErrors++;
            $display("FAILED pc: got %h expected %h", got, exp);
        end
    endtask

    task automatic compareStores(int p);
        int n;
        n = (seenStores.size() < expStores.size()) ? seenStores.size() : expStores.size();
        for (int i = 0; i < n; i++) begin
            checkStore(i, seenStores[i], expStores[i]);
        end
        if (seenStores.size() > expStores.size()) begin
            storeErrors++;
            $display("Program %0d wrote %0d stores but only %0d were expected",
                     p, seenStores.size(), expStores.size());
        end else if (seenStores.size() < expStores.size()) begin
            storeErrors++;
            $display("Program %0d is missing stores, saw %0d of %0d",
                     p, seenStores.size(), expStores.size());
        end
    endtask

    task automatic runProgram(int p);
        int   cycles;
        wordT pcHeld;
        @(posedge clk);
        rstN <= 1'b0;
        for (int c = 0; c < resetCycles; c++) begin
            @(negedge clk);
            checkLevel("dWrite", dWrite, 1'b0);
            checkLevel("hlt", hlt, 1'b0);
            if (c == 0) begin
                buildProgram();
                runReference();
            end
            @(posedge clk);
            loadMem <= (c == 0);
        end
        rstN <= 1'b1;
        @(negedge clk);
        checkLevel("dWrite", dWrite, 1'b0);
        checkLevel("hlt", hlt, 1'b0);
        cycles = 0;
        while (hlt !== 1'b1 && cycles < hltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (hlt !== 1'b1) begin
            ctrlErrors++;
            $display("Program %0d: hlt did not rise within %0d cycles", p, hltTimeout);
            timedOut = 1'b1;
        end else begin
            // Core must stay quiet once halted
            pcHeld = pc;
            for (int c = 0; c < quietCycles; c++) begin
                @(negedge clk);
                checkLevel("dWrite", dWrite, 1'b0);
                checkLevel("hlt", hlt, 1'b1);
                checkPc(pc, pcHeld);
            end
            @(posedge clk);
            compareStores(p);
            for (int a = 0; a < memWords; a++) begin
                checkMemWord(a, dmem[a], expMem[a]);
            end
        end
    endtask

    initial begin
        rstN        = 1'b0;
        loadMem     = 1'b0;
        storeErrors = 0;
        memErrors   = 0;
        ctrlErrors  = 0;
        timedOut    = 1'b0;
        void'($urandom(85));
        for (int a = 0; a < memWords; a++) begin
            imem[a] = {4'hF, 12'(a)};
        end
        for (int p = 0; p < programCount && !timedOut; p++) begin
            runProgram(p);
        end
        $display("Errors: %0d store, %0d memory, %0d control",
                 storeErrors, memErrors, ctrlErrors);
        if (storeErrors + memErrors + ctrlErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- cpu.f
+incdir+include
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/stageRegister.sv
rtl/regFile.sv
rtl/decodeControl.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/cpu.sv
verification/tbCpu.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f cpu.f --top-module tbCpu -Mdir obj_dir -o simCpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simCpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
